//--- countdown_matrix.f
+incdir+testbench
src/matrix_pkg.sv
src/countdown_pkg.sv
src/scan_tick_gen.sv
src/countdown_ctrl.sv
src/glyph_rom.sv
src/dot_matrix_scan.sv
src/countdown_matrix.sv
testbench/tb_countdown_matrix.sv

//--- src/countdown_ctrl.sv
module countdown_ctrl #(
    parameter int STEP_CYCLES = 50_000_000
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                start,
    output matrix_pkg::symbol_e symbol
);

    localparam int CNT_W = (STEP_CYCLES > 1) ? $clog2(STEP_CYCLES) : 1;
    localparam logic [CNT_W-1:0] STEP_LAST = CNT_W'(STEP_CYCLES - 1);

    countdown_pkg::state_e state;
    logic [CNT_W-1:0]      step_cnt;
    logic [2:0]            digit;
    logic                  step_done;

    assign step_done = (step_cnt == STEP_LAST);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state    <= countdown_pkg::ST_IDLE;
            step_cnt <= '0;
            digit    <= countdown_pkg::START_DIGIT;
        end
        else
        begin
            case (state)
                countdown_pkg::ST_IDLE, countdown_pkg::ST_DONE:
                begin
                    if (start)
                    begin
                        state    <= countdown_pkg::ST_COUNT;
                        step_cnt <= '0;
                        digit    <= countdown_pkg::START_DIGIT;
                    end
                end
                countdown_pkg::ST_COUNT:
                begin
                    // Start is ignored here, the digit only moves on step_done.
                    if (step_done)
                    begin
                        step_cnt <= '0;
                        if (digit == 3'd0)
                            state <= countdown_pkg::ST_DONE;
                        else
                            digit <= digit - 3'd1;
                    end
                    else
                    begin
                        step_cnt <= step_cnt + 1'b1;
                    end
                end
                default:
                    state <= countdown_pkg::ST_IDLE;
            endcase
        end
    end

    always_comb
    begin
        case (state)
            countdown_pkg::ST_COUNT: symbol = matrix_pkg::symbol_e'(digit);
            countdown_pkg::ST_DONE:  symbol = matrix_pkg::SYM_HEART;
            default:                 symbol = matrix_pkg::SYM_QUERY;
        endcase
    end

    a_digit_range: assert property (
        @(posedge clk) disable iff (rst)
        (state == countdown_pkg::ST_COUNT) |-> (digit <= countdown_pkg::START_DIGIT)
    );

endmodule

//--- src/countdown_matrix.sv
module countdown_matrix #(
    parameter int SCAN_DIV    = 50_000,
    parameter int STEP_CYCLES = 50_000_000
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             start,
    input  logic             enable,
    output matrix_pkg::col_t row,
    output matrix_pkg::col_t colr,
    output matrix_pkg::col_t colg
);

    logic                scan_tick;
    matrix_pkg::symbol_e symbol;

    scan_tick_gen #(
        .SCAN_DIV (SCAN_DIV)
    ) u_scan_tick_gen (
        .clk       (clk),
        .rst       (rst),
        .scan_tick (scan_tick)
    );

    countdown_ctrl #(
        .STEP_CYCLES (STEP_CYCLES)
    ) u_countdown_ctrl (
        .clk    (clk),
        .rst    (rst),
        .start  (start),
        .symbol (symbol)
    );

    dot_matrix_scan u_dot_matrix_scan (
        .clk       (clk),
        .rst       (rst),
        .enable    (enable),
        .scan_tick (scan_tick),
        .symbol    (symbol),
        .row       (row),
        .colr      (colr),
        .colg      (colg)
    );

endmodule

//--- src/countdown_pkg.sv
package countdown_pkg;

    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_COUNT = 2'd1,
        ST_DONE  = 2'd2
    } state_e;

    // Countdown runs from this digit down to 0.
    localparam logic [2:0] START_DIGIT = 3'd5;

endpackage

//--- src/dot_matrix_scan.sv
module dot_matrix_scan (
    input  logic                clk,
    input  logic                rst,
    input  logic                enable,
    input  logic                scan_tick,
    input  matrix_pkg::symbol_e symbol,
    output matrix_pkg::col_t    row,
    output matrix_pkg::col_t    colr,
    output matrix_pkg::col_t    colg
);

    localparam matrix_pkg::row_idx_t LAST_ROW = matrix_pkg::row_idx_t'(matrix_pkg::ROWS - 1);

    matrix_pkg::symbol_e     symbol_q;
    matrix_pkg::row_idx_t    row_idx;
    matrix_pkg::pixel_line_t line;

    glyph_rom u_glyph_rom (
        .symbol  (symbol_q),
        .row_idx (row_idx),
        .line    (line)
    );

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            symbol_q <= matrix_pkg::SYM_QUERY;
        else
            symbol_q <= symbol;
    end

    // Index parks at row 0 while blanked, so the scan restarts there.
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            row_idx <= '0;
        else if (!enable)
            row_idx <= '0;
        else if (scan_tick)
            row_idx <= (row_idx == LAST_ROW) ? '0 : row_idx + 1'b1;
    end

    // Row drive and columns come from the same index.
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            row  <= '1;
            colr <= '0;
            colg <= '0;
        end
        else if (!enable)
        begin
            row  <= '1;
            colr <= '0;
            colg <= '0;
        end
        else
        begin
            row  <= ~(matrix_pkg::col_t'(1) << row_idx);
            colr <= line.red;
            colg <= line.green;
        end
    end

    a_one_row_low: assert property (
        @(posedge clk) disable iff (rst)
        $countones(~row) <= 1
    );

    a_blank_cols: assert property (
        @(posedge clk) disable iff (rst)
        (row == '1) |-> (colr == '0 && colg == '0)
    );

endmodule

//--- src/glyph_rom.sv
module glyph_rom (
    input  matrix_pkg::symbol_e     symbol,
    input  matrix_pkg::row_idx_t    row_idx,
    output matrix_pkg::pixel_line_t line
);

    // Rows not listed for a glyph stay blank.
    always_comb
    begin
        line = '0;
        case (symbol)
            // Green digits.
            matrix_pkg::SYM_0:
                case (row_idx)
                    3'd1, 3'd7:                   line.green = 8'b0011_1100;
                    3'd2, 3'd3, 3'd4, 3'd5, 3'd6: line.green = 8'b0100_0010;
                    default:                      line = '0;
                endcase
            matrix_pkg::SYM_1:
                case (row_idx)
                    3'd1, 3'd2, 3'd4, 3'd5, 3'd6: line.green = 8'b0001_1000;
                    3'd3:                         line.green = 8'b0011_1000;
                    3'd7:                         line.green = 8'b0111_1110;
                    default:                      line = '0;
                endcase
            // Yellow digits.
            matrix_pkg::SYM_2:
                case (row_idx)
                    3'd1:    line = '{red: 8'b0011_1100, green: 8'b0011_1100};
                    3'd2:    line = '{red: 8'b0110_0110, green: 8'b0110_0110};
                    3'd3:    line = '{red: 8'b0000_0110, green: 8'b0000_0110};
                    3'd4:    line = '{red: 8'b0000_1100, green: 8'b0000_1100};
                    3'd5:    line = '{red: 8'b0011_0000, green: 8'b0011_0000};
                    3'd6:    line = '{red: 8'b0110_0000, green: 8'b0110_0000};
                    3'd7:    line = '{red: 8'b0111_1110, green: 8'b0111_1110};
                    default: line = '0;
                endcase
            matrix_pkg::SYM_3:
                case (row_idx)
                    3'd1, 3'd7: line = '{red: 8'b0011_1100, green: 8'b0011_1100};
                    3'd2, 3'd6: line = '{red: 8'b0110_0110, green: 8'b0110_0110};
                    3'd3, 3'd5: line = '{red: 8'b0000_0110, green: 8'b0000_0110};
                    3'd4:       line = '{red: 8'b0001_1100, green: 8'b0001_1100};
                    default:    line = '0;
                endcase
            // Red digits.
            matrix_pkg::SYM_4:
                case (row_idx)
                    3'd1, 3'd6, 3'd7: line.red = 8'b0000_1100;
                    3'd2:             line.red = 8'b0001_1100;
                    3'd3:             line.red = 8'b0010_1100;
                    3'd4:             line.red = 8'b0100_1100;
                    3'd5:             line.red = 8'b0111_1110;
                    default:          line = '0;
                endcase
            matrix_pkg::SYM_5:
                case (row_idx)
                    3'd1:       line.red = 8'b0111_1110;
                    3'd2:       line.red = 8'b0110_0000;
                    3'd3:       line.red = 8'b0111_1100;
                    3'd4, 3'd5: line.red = 8'b0000_0110;
                    3'd6:       line.red = 8'b0110_0110;
                    3'd7:       line.red = 8'b0011_1100;
                    default:    line = '0;
                endcase
            matrix_pkg::SYM_QUERY:
                case (row_idx)
                    3'd0:       line.red = 8'b0111_1000;
                    3'd1:       line.red = 8'b1100_1100;
                    3'd2:       line.red = 8'b0000_1100;
                    3'd3:       line.red = 8'b0001_1000;
                    3'd4, 3'd6: line.red = 8'b0011_0000;
                    default:    line = '0;
                endcase
            // Heart in yellow, its tip red at the edges.
            matrix_pkg::SYM_HEART:
                case (row_idx)
                    3'd1:    line = '{red: 8'b0010_0010, green: 8'b0010_0010};
                    3'd2:    line = '{red: 8'b0111_0111, green: 8'b0111_0111};
                    3'd3:    line = '{red: 8'b1111_1111, green: 8'b1111_1111};
                    3'd4:    line = '{red: 8'b0111_1111, green: 8'b0111_1111};
                    3'd5:    line = '{red: 8'b0011_1110, green: 8'b0011_1110};
                    3'd6:    line = '{red: 8'b0001_1100, green: 8'b0001_1100};
                    3'd7:    line = '{red: 8'b0001_1100, green: 8'b0000_1000};
                    default: line = '0;
                endcase
            default:
                line = '0;
        endcase
    end

endmodule

//--- src/matrix_pkg.sv
package matrix_pkg;

    // Square matrix, one row driven at a time.
    localparam int ROWS = 8;

    typedef logic [$clog2(ROWS)-1:0] row_idx_t;

    // Bit 7 is the leftmost LED, a 1 lights it.
    typedef logic [ROWS-1:0] col_t;

    // Codes 0 to 5 show the digit of the same value.
    typedef enum logic [2:0] {
        SYM_0     = 3'd0,
        SYM_1     = 3'd1,
        SYM_2     = 3'd2,
        SYM_3     = 3'd3,
        SYM_4     = 3'd4,
        SYM_5     = 3'd5,
        SYM_QUERY = 3'd6,
        SYM_HEART = 3'd7
    } symbol_e;

    // Red and green columns for one row. Both lit shows yellow.
    typedef struct packed {
        col_t red;
        col_t green;
    } pixel_line_t;

endpackage

//--- src/scan_tick_gen.sv
module scan_tick_gen #(
    parameter int SCAN_DIV = 50_000
) (
    input  logic clk,
    input  logic rst,
    output logic scan_tick
);

    localparam int CNT_W = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;
    localparam logic [CNT_W-1:0] RELOAD = CNT_W'(SCAN_DIV - 1);

    logic [CNT_W-1:0] cnt;

    // Tick is registered on the cycle the counter wraps.
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            cnt       <= RELOAD;
            scan_tick <= 1'b0;
        end
        else if (cnt == '0)
        begin
            cnt       <= RELOAD;
            scan_tick <= 1'b1;
        end
        else
        begin
            cnt       <= cnt - 1'b1;
            scan_tick <= 1'b0;
        end
    end

endmodule

//--- testbench/tb_glyph_model.svh
`ifndef TB_GLYPH_MODEL_SVH
`define TB_GLYPH_MODEL_SVH

// Each glyph is held as eight row bytes, row 0 in the top byte.
// Returns {red, green} for one row.
function automatic logic [15:0] glyph_line_model(input logic [2:0] sym, input logic [2:0] r);
    logic [63:0] red;
    logic [63:0] green;
    red   = '0;
    green = '0;
    case (sym)
        3'd0: {red, green} = {64'h0, 64'h003C_4242_4242_423C};
        3'd1: {red, green} = {64'h0, 64'h0018_1838_1818_187E};
        3'd2: {red, green} = {64'h003C_6606_0C30_607E, 64'h003C_6606_0C30_607E};
        3'd3: {red, green} = {64'h003C_6606_1C06_663C, 64'h003C_6606_1C06_663C};
        3'd4: {red, green} = {64'h000C_1C2C_4C7E_0C0C, 64'h0};
        3'd5: {red, green} = {64'h007E_607C_0606_663C, 64'h0};
        3'd6: {red, green} = {64'h78CC_0C18_3000_3000, 64'h0};
        // Heart tip is red only.
        3'd7: {red, green} = {64'h0022_77FF_7F3E_1C1C, 64'h0022_77FF_7F3E_1C08};
        default: {red, green} = '0;
    endcase
    return {red[(7 - r) * 8 +: 8], green[(7 - r) * 8 +: 8]};
endfunction

`endif

//--- testbench/tb_countdown_matrix.sv
module tb_countdown_matrix;

    localparam int SCAN_DIV     = 3;
    localparam int STEP_CYCLES  = 40;
    localparam int RUN_CYCLES   = 3000;
    localparam int QUIET_CYCLES = 30;
    localparam int CLK_PERIOD   = 8;
    localparam int TIMEOUT      = (10 + RUN_CYCLES + 200) * CLK_PERIOD;

    logic                  clk;
    logic                  rst;
    logic                  start;
    logic                  enable;
    matrix_pkg::col_t      row;
    matrix_pkg::col_t      colr;
    matrix_pkg::col_t      colg;
    logic [15:0]           lfsr;
    int                    errors;
    countdown_pkg::state_e m_state;
    int                    m_cnt;
    int                    m_digit;
    logic [2:0]            sym_now;
    logic [2:0]            sym_d1;
    logic [2:0]            sym_d2;
    int                    last_row;
    int                    row_cycles;
    logic                  full_run;

    `include "tb_glyph_model.svh"

    countdown_matrix #(
        .SCAN_DIV    (SCAN_DIV),
        .STEP_CYCLES (STEP_CYCLES)
    ) uut (
        .clk    (clk),
        .rst    (rst),
        .start  (start),
        .enable (enable),
        .row    (row),
        .colr   (colr),
        .colg   (colg)
    );

    initial
        clk = 1'b0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Taps 16, 14, 13, 11.
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_random_bits(input int n, output logic [7:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_step(lfsr);
            bits = {bits[6:0], lfsr[0]};
        end
    endtask

    task automatic check_value(input logic [15:0] got, input logic [15:0] exp, input string what);
        if (got !== exp)
        begin
            $display("Error at time %0t: %s, got %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    // Advances the countdown model by one clock edge.
    task automatic advance_countdown(input logic start_seen);
        if (m_state == countdown_pkg::ST_COUNT)
        begin
            if (m_cnt == STEP_CYCLES - 1)
            begin
                m_cnt = 0;
                if (m_digit == 0)
                    m_state = countdown_pkg::ST_DONE;
                else
                    m_digit--;
            end
            else
                m_cnt++;
        end
        else if (start_seen)
        begin
            m_state = countdown_pkg::ST_COUNT;
            m_cnt   = 0;
            m_digit = 5;
        end
        sym_now = (m_state == countdown_pkg::ST_COUNT) ? 3'(m_digit) :
                  (m_state == countdown_pkg::ST_DONE) ? 3'd7 : 3'd6;
    endtask

    task automatic check_outputs(input logic enabled, input logic [2:0] sym);
        int idx;
        idx = -1;
        for (int i = 0; i < 8; i++)
            if (!row[i])
                idx = i;
        check_value(16'($countones(~row)), enabled ? 16'd1 : 16'd0, "number of low row lines");
        if (!enabled)
        begin
            check_value({colr, colg}, 16'h0000, "columns while blanked");
            last_row = -1;
        end
        else if (idx >= 0)
        begin
            if (last_row < 0)
            begin
                check_value(16'(idx), 16'd0, "first row after blanking");
                row_cycles = 1;
                full_run   = 1'b0;
            end
            else if (idx != last_row)
            begin
                check_value(16'(idx), 16'((last_row + 1) % 8), "next scanned row");
                // A row entered from its predecessor is held for one whole tick period.
                if (full_run)
                    check_value(16'(row_cycles), 16'(SCAN_DIV), "cycles spent on one row");
                row_cycles = 1;
                full_run   = 1'b1;
            end
            else
                row_cycles++;
            // The first row after reset may run one cycle past a tick period.
            check_value(16'(row_cycles > SCAN_DIV + 1), 16'd0, "row held past a scan tick");
            check_value({colr, colg}, glyph_line_model(sym, 3'(idx)),
                        $sformatf("columns for symbol %0d row %0d", sym, idx));
            last_row = idx;
        end
    endtask

    initial
    begin
        logic [7:0] bits;
        rst        = 1'b1;
        start      = 1'b0;
        enable     = 1'b0;
        lfsr       = 16'd75;
        errors     = 0;
        m_state    = countdown_pkg::ST_IDLE;
        m_cnt      = 0;
        m_digit    = 5;
        sym_now    = 3'd6;
        sym_d1     = 3'd6;
        sym_d2     = 3'd6;
        last_row   = -1;
        row_cycles = 0;
        full_run   = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        check_outputs(1'b0, sym_d2);
        rst    = 1'b0;
        enable = 1'b1;
        for (int cyc = 0; cyc < RUN_CYCLES; cyc++)
        begin
            @(posedge clk);
            #1;
            // Symbol reaches the columns two edges after the controller.
            sym_d2 = sym_d1;
            sym_d1 = sym_now;
            advance_countdown(start);
            check_outputs(enable, sym_d2);
            take_random_bits(4, bits);
            start = (bits[3:0] == 4'd0) && (cyc >= QUIET_CYCLES);
            take_random_bits(6, bits);
            if (bits[5:0] == 6'd0)
                enable = ~enable;
        end
        $display("Run finished after %0d cycles with %0d error(s)", RUN_CYCLES, errors);
        if (errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

    initial
    begin
        #(TIMEOUT);
        $display("Timeout: the run did not finish within %0d time units", TIMEOUT);
        $display("TEST FAIL");
        $finish;
    end

endmodule
